// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bbox_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bbox/bbox_extent.sv ====
// Raw triangle extent: signed minimum and maximum of x and y across the three vertices
`default_nettype none

`include "bbox_params.svh"

module bbox_extent (
    input  bbox_pkg::tri_t tri_in,
    output bbox_pkg::box_t raw_box
);

    // Per-vertex coordinates, indexed so the mux can loop over them
    bbox_pkg::coord_t vx [`BBOX_VERTS];
    bbox_pkg::coord_t vy [`BBOX_VERTS];

    // Pairwise signed compares
    // bit 0 is v0 < v1, bit 1 is v0 < v2, bit 2 is v1 < v2
    logic [2:0] cmp_x;
    logic [2:0] cmp_y;

    // One-hot vertex selects for each corner
    logic [`BBOX_VERTS-1:0] sel_min_x;
    logic [`BBOX_VERTS-1:0] sel_min_y;
    logic [`BBOX_VERTS-1:0] sel_max_x;
    logic [`BBOX_VERTS-1:0] sel_max_y;

    // Decode compares into the minimum vertex
    // Equal values fall through to the higher vertex so exactly one bit is set
    function automatic logic [`BBOX_VERTS-1:0] min_sel(input logic [2:0] c);
        logic [`BBOX_VERTS-1:0] s;
        s[0] = c[0] & c[1];
        s[1] = ~c[0] & c[2];
        s[2] = ~c[1] & ~c[2];
        return s;
    endfunction

    // Same for the maximum, ties land on the lower vertex here
    function automatic logic [`BBOX_VERTS-1:0] max_sel(input logic [2:0] c);
        logic [`BBOX_VERTS-1:0] s;
        s[0] = ~c[0] & ~c[1];
        s[1] = c[0] & ~c[2];
        s[2] = c[1] & c[2];
        return s;
    endfunction

    // One-hot mux over the vertices
    function automatic bbox_pkg::coord_t pick(input logic [`BBOX_VERTS-1:0] sel,
                                              input bbox_pkg::coord_t v [`BBOX_VERTS]);
        bbox_pkg::coord_t r;
        r = '0;
        for (int i = 0; i < `BBOX_VERTS; i++) begin
            if (sel[i]) begin
                r = v[i];
            end
        end
        return r;
    endfunction

    assign vx[0] = tri_in.v0.x;
    assign vx[1] = tri_in.v1.x;
    assign vx[2] = tri_in.v2.x;
    assign vy[0] = tri_in.v0.y;
    assign vy[1] = tri_in.v1.y;
    assign vy[2] = tri_in.v2.y;

    // coord_t is signed, so these are signed compares
    assign cmp_x = {vx[1] < vx[2], vx[0] < vx[2], vx[0] < vx[1]};
    assign cmp_y = {vy[1] < vy[2], vy[0] < vy[2], vy[0] < vy[1]};

    assign sel_min_x = min_sel(cmp_x);
    assign sel_min_y = min_sel(cmp_y);
    assign sel_max_x = max_sel(cmp_x);
    assign sel_max_y = max_sel(cmp_y);

    // Corners straight from the selected vertices
    assign raw_box.ll_x = pick(sel_min_x, vx);
    assign raw_box.ll_y = pick(sel_min_y, vy);
    assign raw_box.ur_x = pick(sel_max_x, vx);
    assign raw_box.ur_y = pick(sel_max_y, vy);

endmodule

`default_nettype wire

// ==== bbox/bbox_snap_clip.sv ====
// Snaps the raw box to the MSAA sample grid, clamps it to the screen and flags off-screen boxes
`default_nettype none

`include "bbox_params.svh"

module bbox_snap_clip (
    input  bbox_pkg::box_t       raw_box,
    input  bbox_pkg::screen_t    screen,
    input  bbox_pkg::subsample_t subsample,
    output bbox_pkg::box_t       box,
    output logic                 keep
);

    // Enough bits to count up to RADIX cleared fraction bits
    localparam int CLR_W = $clog2(`BBOX_RADIX + 1);

    // Signed zero, keeps every compare below signed
    localparam bbox_pkg::coord_t ZERO = '0;

    // Number of low fraction bits to drop for the current grid
    logic [CLR_W-1:0] frac_clr;

    // All ones above the grid step, zeros below
    bbox_pkg::coord_t frac_mask;

    // Box floored to the grid, before clamping
    bbox_pkg::box_t snapped;

    // Finer grids keep more fraction bits
    always_comb begin
        case (subsample)
            bbox_pkg::SS_1X:  frac_clr = CLR_W'(`BBOX_RADIX);
            bbox_pkg::SS_4X:  frac_clr = CLR_W'(`BBOX_RADIX - 1);
            bbox_pkg::SS_16X: frac_clr = CLR_W'(`BBOX_RADIX - 2);
            bbox_pkg::SS_64X: frac_clr = CLR_W'(`BBOX_RADIX - 3);
            // Illegal codes snap like 1x
            default:          frac_clr = CLR_W'(`BBOX_RADIX);
        endcase
    end

    assign frac_mask = {`BBOX_SIGFIG{1'b1}} << frac_clr;

    // Clearing low bits of a two's complement value is a floor,
    // negative corners move further from zero
    assign snapped.ll_x = raw_box.ll_x & frac_mask;
    assign snapped.ll_y = raw_box.ll_y & frac_mask;
    assign snapped.ur_x = raw_box.ur_x & frac_mask;
    assign snapped.ur_y = raw_box.ur_y & frac_mask;

    // Lower-left only clamps at the origin
    always_comb begin
        box.ll_x = snapped.ll_x;
        box.ll_y = snapped.ll_y;
        if (snapped.ll_x < ZERO) begin
            box.ll_x = ZERO;
        end
        if (snapped.ll_y < ZERO) begin
            box.ll_y = ZERO;
        end
    end

    // Upper-right only clamps at the far screen edge
    always_comb begin
        box.ur_x = snapped.ur_x;
        box.ur_y = snapped.ur_y;
        if (snapped.ur_x > screen.width) begin
            box.ur_x = screen.width;
        end
        if (snapped.ur_y > screen.height) begin
            box.ur_y = screen.height;
        end
    end

    // Reject when the snapped box lies wholly left, below, right or above the screen
    // Uses the unclamped corners, after clamping every box would look on-screen
    assign keep = (snapped.ur_x >= ZERO) &&
                  (snapped.ur_y >= ZERO) &&
                  (snapped.ll_x <= screen.width) &&
                  (snapped.ll_y <= screen.height);

endmodule

`default_nettype wire

// ==== bbox/bbox_top.sv ====
// Bounding-box stage top: extent, grid snap and screen clip, then a freezable three-stage pipe
`default_nettype none

`include "bbox_params.svh"

module bbox_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // Triangle in, one per advancing cycle while valid_in is high
    input  bbox_pkg::tri_t       tri_in,
    input  bbox_pkg::color_t     color_in,
    input  logic                 valid_in,

    // Configuration, steady while triangles are valid
    input  bbox_pkg::screen_t    screen,
    input  bbox_pkg::subsample_t subsample,

    // High moves the pipe, low holds every stage
    input  logic                 advance,

    // Triangle out with its clamped box
    output bbox_pkg::tri_t       tri_out,
    output bbox_pkg::color_t     color_out,
    output bbox_pkg::box_t       box_out,
    output logic                 valid_out
);

    // Unsnapped min/max corners
    bbox_pkg::box_t raw_box;

    // Snapped and clamped corners
    bbox_pkg::box_t box;

    // Box touches the screen
    logic keep;

    // Input valid with off-screen triangles dropped
    logic valid_keep;

    // Pipe payload at both ends
    bbox_pkg::bbox_item_t item_in;
    bbox_pkg::bbox_item_t item_out;

    bbox_extent u_extent (
        .tri_in  (tri_in),
        .raw_box (raw_box)
    );

    bbox_snap_clip u_snap_clip (
        .raw_box   (raw_box),
        .screen    (screen),
        .subsample (subsample),
        .box       (box),
        .keep      (keep)
    );

    // Box is computed before the first register, so the pipe only delays
    always_comb begin
        item_in.triangle = tri_in;
        item_in.color    = color_in;
        item_in.box      = box;
    end

    assign valid_keep = valid_in & keep;

    stage_pipe #(
        .payload_t (bbox_pkg::bbox_item_t),
        .DEPTH     (`BBOX_PIPE_DEPTH)
    ) u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .valid_in  (valid_keep),
        .data_in   (item_in),
        .valid_out (valid_out),
        .data_out  (item_out)
    );

    // Unpack the last stage
    assign tri_out   = item_out.triangle;
    assign color_out = item_out.color;
    assign box_out   = item_out.box;

endmodule

`default_nettype wire

// ==== common/bbox_params.svh ====
// Bounding-box stage constants for fixed-point format, vertex count and pipeline depth
`ifndef BBOX_PARAMS_SVH
`define BBOX_PARAMS_SVH

// Width of every coordinate and colour channel
`define BBOX_SIGFIG 24

// Fraction bits in a coordinate
// Integer part sits in [SIGFIG-1:RADIX], fraction in [RADIX-1:0]
`define BBOX_RADIX 10

// Vertices per triangle
`define BBOX_VERTS 3

// Register stages from input to output
`define BBOX_PIPE_DEPTH 3

`endif

// ==== common/bbox_pkg.sv ====
// Shared types for the bounding-box stage: coordinates, triangles, colours, boxes and pipe items
`default_nettype none

`include "bbox_params.svh"

package bbox_pkg;

    // Signed fixed point, RADIX fraction bits
    typedef logic signed [`BBOX_SIGFIG-1:0] coord_t;

    // One vertex, z only rides along
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_t;

    // Unsigned colour channels, passed through untouched
    typedef struct packed {
        logic [`BBOX_SIGFIG-1:0] r;
        logic [`BBOX_SIGFIG-1:0] g;
        logic [`BBOX_SIGFIG-1:0] b;
    } color_t;

    // Lower-left and upper-right corners
    typedef struct packed {
        coord_t ll_x;
        coord_t ll_y;
        coord_t ur_x;
        coord_t ur_y;
    } box_t;

    // Screen size in the same fixed-point format as the vertices
    typedef struct packed {
        coord_t width;
        coord_t height;
    } screen_t;

    // One-hot MSAA code
    typedef logic [3:0] subsample_t;

    // 1x, step of one pixel; also what an illegal code falls back to
    localparam subsample_t SS_1X  = 4'b1000;
    // 4x, half-pixel step
    localparam subsample_t SS_4X  = 4'b0100;
    // 16x, quarter-pixel step
    localparam subsample_t SS_16X = 4'b0010;
    // 64x, eighth-pixel step
    localparam subsample_t SS_64X = 4'b0001;

    // Everything that moves down the pipe with a triangle
    typedef struct packed {
        tri_t   triangle;
        color_t color;
        box_t   box;
    } bbox_item_t;

endpackage

`default_nettype wire

// ==== list.f ====
+incdir+common
common/bbox_pkg.sv
bbox/bbox_extent.sv
bbox/bbox_snap_clip.sv
verilog/stage_pipe.sv
bbox/bbox_top.sv
testbench/bbox_sva.sv
testbench/bbox_tb.sv

// ==== testbench/bbox_sva.sv ====
// Bound checks on the bounding-box top: reset, box ordering, screen limits and stall hold
`default_nettype none

module bbox_sva (
    input logic              clk,
    input logic              rst_n,
    input logic              advance,
    input bbox_pkg::screen_t screen,
    input bbox_pkg::tri_t    tri_out,
    input bbox_pkg::color_t  color_out,
    input bbox_pkg::box_t    box_out,
    input logic              valid_out
);

    // No valid output while held in reset
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !valid_out)
        else $error("valid_out high during reset");

    // Corners stay ordered
    a_box_order: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> (box_out.ll_x <= box_out.ur_x) && (box_out.ll_y <= box_out.ur_y))
        else $error("box corners out of order");

    // Box lies on the screen after clamping
    a_box_screen: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> (box_out.ll_x >= 0) && (box_out.ll_y >= 0) &&
                      (box_out.ur_x <= screen.width) && (box_out.ur_y <= screen.height))
        else $error("box outside the screen");

    // Frozen pipe holds every output
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !advance |=> $stable(valid_out) && $stable(box_out) &&
                     $stable(tri_out) && $stable(color_out))
        else $error("outputs moved while advance was low");

endmodule

bind bbox_top bbox_sva u_sva (.*);

`default_nettype wire

// ==== testbench/bbox_tb.sv ====
// Directed-test testbench for the bounding-box stage against a reference model, with stalls
`default_nettype none

`include "bbox_params.svh"

module bbox_tb;

    logic                 clk;
    logic                 rst_n;
    bbox_pkg::tri_t       tri_in;
    bbox_pkg::color_t     color_in;
    logic                 valid_in;
    bbox_pkg::screen_t    screen;
    bbox_pkg::subsample_t subsample;
    logic                 advance;
    bbox_pkg::tri_t       tri_out;
    bbox_pkg::color_t     color_out;
    bbox_pkg::box_t       box_out;
    logic                 valid_out;

    // Expected items and the advancing-edge count at which each was sampled
    bbox_pkg::bbox_item_t exp_q [$];
    int                   stamp_q [$];

    string                cur_test;
    logic [31:0]          lfsr_state;
    int                   mismatch_errs;
    int                   other_errs;
    int                   cycles;
    int                   adv_count;
    logic                 adv_seen;
    // Last edge had advance low out of reset
    logic                 stalled;
    logic                 stall_en;

    // Last sampled outputs for the hold check
    logic                 prev_valid;
    bbox_pkg::box_t       prev_box;
    bbox_pkg::tri_t       prev_tri;
    bbox_pkg::color_t     prev_color;

    bbox_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic step_lfsr();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], step_lfsr()};
        end
        return r;
    endfunction

    // Full-width random channels
    function automatic bbox_pkg::color_t rand_color();
        bbox_pkg::color_t c;
        c.r = 24'(rand_bits(24));
        c.g = 24'(rand_bits(24));
        c.b = 24'(rand_bits(24));
        return c;
    endfunction

    // z is random pass-through data
    function automatic bbox_pkg::tri_t mk_tri(input int x0, input int y0, input int x1,
                                              input int y1, input int x2, input int y2);
        bbox_pkg::tri_t t;
        t.v0 = '{bbox_pkg::coord_t'(x0), bbox_pkg::coord_t'(y0), bbox_pkg::coord_t'(rand_bits(24))};
        t.v1 = '{bbox_pkg::coord_t'(x1), bbox_pkg::coord_t'(y1), bbox_pkg::coord_t'(rand_bits(24))};
        t.v2 = '{bbox_pkg::coord_t'(x2), bbox_pkg::coord_t'(y2), bbox_pkg::coord_t'(rand_bits(24))};
        return t;
    endfunction

    function automatic bbox_pkg::coord_t min3(input bbox_pkg::coord_t a, input bbox_pkg::coord_t b,
                                              input bbox_pkg::coord_t c);
        bbox_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic bbox_pkg::coord_t max3(input bbox_pkg::coord_t a, input bbox_pkg::coord_t b,
                                              input bbox_pkg::coord_t c);
        bbox_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Reference box from extent, floor by shifting, clamp and the keep rule
    function automatic bbox_pkg::box_t expect_box(input bbox_pkg::tri_t t,
                                                  input bbox_pkg::screen_t s,
                                                  input bbox_pkg::subsample_t ss,
                                                  output logic k);
        bbox_pkg::box_t b;
        int sh;
        sh = (ss == 4'b0100) ? 9 : (ss == 4'b0010) ? 8 : (ss == 4'b0001) ? 7 : 10;
        b.ll_x = (min3(t.v0.x, t.v1.x, t.v2.x) >>> sh) <<< sh;
        b.ll_y = (min3(t.v0.y, t.v1.y, t.v2.y) >>> sh) <<< sh;
        b.ur_x = (max3(t.v0.x, t.v1.x, t.v2.x) >>> sh) <<< sh;
        b.ur_y = (max3(t.v0.y, t.v1.y, t.v2.y) >>> sh) <<< sh;
        k = b.ur_x >= 0 && b.ur_y >= 0 && b.ll_x <= s.width && b.ll_y <= s.height;
        if (b.ll_x < 0) b.ll_x = '0;
        if (b.ll_y < 0) b.ll_y = '0;
        if (b.ur_x > s.width) b.ur_x = s.width;
        if (b.ur_y > s.height) b.ur_y = s.height;
        return b;
    endfunction

    task automatic check_box(input bbox_pkg::box_t exp, input bbox_pkg::box_t act);
        if (exp !== act) begin
            mismatch_errs++;
            $display("mismatch %s box: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_tri(input bbox_pkg::tri_t exp, input bbox_pkg::tri_t act);
        if (exp !== act) begin
            mismatch_errs++;
            $display("mismatch %s tri: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_color(input bbox_pkg::color_t exp, input bbox_pkg::color_t act);
        if (exp !== act) begin
            mismatch_errs++;
            $display("mismatch %s color: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (exp !== act) begin
            mismatch_errs++;
            $display("mismatch %s valid: expected %b actual %b", cur_test, exp, act);
        end
    endtask

    // Inputs read here are the values the DUT samples on this edge
    always @(posedge clk) begin
        record_expected();
    end

    task automatic record_expected();
        bbox_pkg::box_t       eb;
        bbox_pkg::bbox_item_t item;
        logic                 k;
        cycles++;
        adv_seen = advance && rst_n;
        stalled  = rst_n && !advance;
        if (adv_seen) begin
            if (valid_in) begin
                eb = expect_box(tri_in, screen, subsample, k);
                // Rejected triangles never show up at the output
                if (k) begin
                    item.triangle = tri_in;
                    item.color    = color_in;
                    item.box      = eb;
                    exp_q.push_back(item);
                    stamp_q.push_back(adv_count);
                end
            end
            adv_count++;
        end
    endtask

    // Outputs sampled on the falling edge where everything has settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (adv_seen && valid_out) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("%s: valid_out high with no triangle expected", cur_test);
                end else begin
                    check_tri(exp_q[0].triangle, tri_out);
                    check_color(exp_q[0].color, color_out);
                    check_box(exp_q[0].box, box_out);
                    // Latency counts advancing edges only
                    if (adv_count - stamp_q[0] != `BBOX_PIPE_DEPTH) begin
                        other_errs++;
                        $display("%s: triangle came out after the wrong number of edges",
                                 cur_test);
                    end
                    void'(exp_q.pop_front());
                    void'(stamp_q.pop_front());
                end
            end else if (stalled) begin
                // Frozen pipe keeps every output
                check_valid(prev_valid, valid_out);
                check_box(prev_box, box_out);
                check_tri(prev_tri, tri_out);
                check_color(prev_color, color_out);
            end
        end
        prev_valid = valid_out;
        prev_box   = box_out;
        prev_tri   = tri_out;
        prev_color = color_out;
    end

    // Holds each triangle until an edge with advance high has taken it
    task automatic send(input bbox_pkg::tri_t t, input bbox_pkg::subsample_t ss);
        logic a;
        @(posedge clk);
        tri_in    <= t;
        color_in  <= rand_color();
        subsample <= ss;
        valid_in  <= 1'b1;
        a = stall_en ? rand_bits(1)[0] : 1'b1;
        advance <= a;
        while (!a) begin
            @(posedge clk);
            a = stall_en ? rand_bits(1)[0] : 1'b1;
            advance <= a;
        end
    endtask

    // Flush the pipe and wait for every expected triangle
    task automatic drain();
        int n;
        @(posedge clk);
        valid_in <= 1'b0;
        advance  <= 1'b1;
        n = 0;
        while (exp_q.size() > 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            other_errs++;
            $display("%s: %0d expected triangles never appeared", cur_test, exp_q.size());
            exp_q.delete();
            stamp_q.delete();
        end
    endtask

    // Random triangles inside the 64x48 screen
    task automatic test_inside();
        cur_test = "inside";
        for (int i = 0; i < 10; i++) begin
            send(mk_tri(rand_bits(16), rand_bits(15), rand_bits(16), rand_bits(15),
                        rand_bits(16), rand_bits(15)), 4'b1000);
        end
        drain();
    endtask

    // One triangle with fractional corners under every code and one illegal code
    task automatic test_subsample();
        bbox_pkg::tri_t t;
        bbox_pkg::subsample_t codes [5];
        cur_test = "subsample";
        codes = '{4'b1000, 4'b0100, 4'b0010, 4'b0001, 4'b0011};
        t = mk_tri((3 << 10) + 731, (2 << 10) + 901, (10 << 10) + 389,
                   (9 << 10) + 515, (6 << 10) + 97, (5 << 10) + 260);
        foreach (codes[i]) begin
            send(t, codes[i]);
        end
        drain();
    endtask

    // Clamped on all sides, then wholly left, below, right and above
    task automatic test_clip();
        cur_test = "clip";
        send(mk_tri(-(5 << 10) - 300, -(3 << 10), 70 << 10, 20 << 10, 30 << 10, 50 << 10), 4'b0100);
        send(mk_tri(-(20 << 10), 5 << 10, -(5 << 10), 9 << 10, -(9 << 10), 30 << 10), 4'b1000);
        send(mk_tri(5 << 10, -(20 << 10), 9 << 10, -(5 << 10), 30 << 10, -(9 << 10)), 4'b1000);
        send(mk_tri(70 << 10, 5 << 10, 90 << 10, 9 << 10, 80 << 10, 30 << 10), 4'b0010);
        send(mk_tri(5 << 10, 50 << 10, 9 << 10, 60 << 10, 30 << 10, 70 << 10), 4'b0001);
        drain();
    endtask

    task automatic test_stall();
        cur_test = "stall";
        stall_en = 1'b1;
        for (int i = 0; i < 12; i++) begin
            send(mk_tri(rand_bits(16), rand_bits(15), rand_bits(16), rand_bits(15),
                        rand_bits(16), rand_bits(15)), 4'b0010);
        end
        stall_en = 1'b0;
        drain();
    endtask

    // Run limit several times the length of all tests
    always @(posedge clk) begin
        if (cycles >= 2000) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        lfsr_state    = 32'h3e27;
        mismatch_errs = 0;
        other_errs    = 0;
        cycles        = 0;
        adv_count     = 0;
        adv_seen      = 1'b0;
        stalled       = 1'b0;
        stall_en      = 1'b0;
        rst_n         = 1'b0;
        tri_in        = '0;
        color_in      = '0;
        // A triangle offered during reset must not reach the output
        valid_in      = 1'b1;
        advance       = 1'b1;
        subsample     = 4'b1000;
        screen        = '{bbox_pkg::coord_t'(64 << 10), bbox_pkg::coord_t'(48 << 10)};
        cur_test      = "reset";
        repeat (16) begin
            @(negedge clk);
            check_valid(1'b0, valid_out);
        end
        @(posedge clk);
        rst_n    <= 1'b1;
        valid_in <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_valid(1'b0, valid_out);
        end
        test_inside();
        test_subsample();
        test_clip();
        test_stall();
        repeat (4) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/stage_pipe.sv ====
// Enabled register chain with a reset valid bit per stage, generic over its payload type
`default_nettype none

`include "bbox_params.svh"

module stage_pipe #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `BBOX_PIPE_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    // Stage 0 is loaded from the input, stage DEPTH-1 drives the output
    payload_t         data_q [DEPTH];
    logic [DEPTH-1:0] valid_q;

    // Valid bits are the only control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q[0] <= valid_in;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload shifts on the same enable
    // Low advance freezes every stage
    always_ff @(posedge clk) begin
        if (advance) begin
            data_q[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    assign valid_out = valid_q[DEPTH-1];
    assign data_out  = data_q[DEPTH-1];

endmodule

`default_nettype wire
